/* Bender.yml */
package:
  name: adpll_mesh

sources:
  - rtl/ring_net_pkg.sv
  - rtl/phase_accum.sv
  - rtl/phase_detector.sv
  - rtl/error_combiner.sv
  - rtl/loop_filter.sv
  - rtl/adpll_node.sv
  - rtl/mesh_config.sv
  - rtl/adpll_mesh_top.sv
  - target: test
    files:
      - verification/adpll_mesh_tb.sv

/* list.f */
rtl/ring_net_pkg.sv
rtl/phase_accum.sv
rtl/phase_detector.sv
rtl/error_combiner.sv
rtl/loop_filter.sv
rtl/adpll_node.sv
rtl/mesh_config.sv
rtl/adpll_mesh_top.sv
verification/adpll_mesh_tb.sv

/* rtl/adpll_mesh_top.sv */
`timescale 1ns/100ps

module adpll_mesh_top #(
    parameter int BIAS    = 30,
    parameter int KP_FRAC = 3,
    parameter int KI_FRAC = 6
) (
    input  logic                       clk258_x,
    input  logic                       reset_i,
    input  ring_net_pkg::switch_word_u cfg_word_i,
    output logic                       ref_clk_o,
    output logic [3:0]                 gen_o,
    output ring_net_pkg::node_err_t    err11_o,
    output ring_net_pkg::gain_cfg_t    gains_o
);
    import ring_net_pkg::*;

    localparam int N11 = 0;
    localparam int N12 = 1;
    localparam int N21 = 2;
    localparam int N22 = 3;

    logic [ACCUM_WIDTH-1:0] ref_word;
    gain_cfg_t              gains;
    logic                   enable;
    weight_set_t [0:3]      weights;
    logic [3:0]             div8;
    logic [3:0]             ref_left;
    logic [3:0]             ref_above;
    node_err_t [0:3]        err;
    node_err_t [0:3]        right_err;
    node_err_t [0:3]        below_err;

    mesh_config u_cfg (
        .clk258_x   (clk258_x),
        .reset_i    (reset_i),
        .cfg_word_i (cfg_word_i),
        .ref_word_o (ref_word),
        .gains_o    (gains),
        .enable_o   (enable),
        .weights_o  (weights)
    );

    phase_accum #(
        .WIDTH (ACCUM_WIDTH)
    ) u_ref_nco (
        .clk258_x (clk258_x),
        .reset_i  (reset_i),
        .word_i   (ref_word),
        .clk_o    (ref_clk_o)
    );

    assign ref_left[N11]  = ref_clk_o;
    assign ref_above[N11] = div8[N11];    // no upper neighbour, loops back
    assign right_err[N11] = err[N12];
    assign below_err[N11] = err[N21];

    assign ref_left[N12]  = div8[N11];
    assign ref_above[N12] = div8[N12];
    assign right_err[N12] = '0;
    assign below_err[N12] = err[N22];

    assign ref_left[N21]  = div8[N21];    // no left neighbour
    assign ref_above[N21] = div8[N11];
    assign right_err[N21] = err[N22];
    assign below_err[N21] = '0;

    assign ref_left[N22]  = div8[N21];
    assign ref_above[N22] = div8[N12];
    assign right_err[N22] = '0;
    assign below_err[N22] = '0;

    for (genvar g = 0; g < 4; g++)
    begin : g_node
        adpll_node #(
            .BIAS    (BIAS),
            .KP_FRAC (KP_FRAC),
            .KI_FRAC (KI_FRAC)
        ) u_node (
            .clk258_x    (clk258_x),
            .reset_i     (reset_i),
            .enable_i    (enable),
            .ref_left_i  (ref_left[g]),
            .ref_above_i (ref_above[g]),
            .gains_i     (gains),
            .weights_i   (weights[g]),
            .right_i     (right_err[g]),
            .below_i     (below_err[g]),
            .err_o       (err[g]),
            .gen_o       (gen_o[g]),
            .div8_o      (div8[g])
        );
    end

    assign err11_o = err[N11];
    assign gains_o = gains;  // for the display

endmodule

/* rtl/adpll_node.sv */
`timescale 1ns/100ps

module adpll_node #(
    parameter int BIAS    = 30,
    parameter int KP_FRAC = 3,
    parameter int KI_FRAC = 6
) (
    input  logic                      clk258_x,
    input  logic                      reset_i,
    input  logic                      enable_i,
    input  logic                      ref_left_i,
    input  logic                      ref_above_i,
    input  ring_net_pkg::gain_cfg_t   gains_i,
    input  ring_net_pkg::weight_set_t weights_i,
    input  ring_net_pkg::node_err_t   right_i,
    input  ring_net_pkg::node_err_t   below_i,
    output ring_net_pkg::node_err_t   err_o,
    output logic                      gen_o,
    output logic                      div8_o
);
    import ring_net_pkg::*;

    pdet_err_t                   left_err, above_err;
    logic                        left_valid, above_valid;
    node_err_t                   err_q;    // latest detector results
    node_err_t                   err_now;  // includes this cycle's strobes
    logic signed [SUM_WIDTH-1:0] sum;
    logic                        sum_valid;
    logic signed [DCO_WIDTH-1:0] ctrl;
    logic signed [DCO_WIDTH:0]   word_sum;
    logic [DCO_WIDTH-1:0]        dco_word;
    logic                        gen_d;
    logic [2:0]                  div_q;

    phase_detector u_det_left (
        .clk258_x    (clk258_x),
        .reset_i     (reset_i),
        .ref_i       (ref_left_i),
        .fb_i        (div8_o),
        .err_o       (left_err),
        .err_valid_o (left_valid)
    );

    phase_detector u_det_above (
        .clk258_x    (clk258_x),
        .reset_i     (reset_i),
        .ref_i       (ref_above_i),
        .fb_i        (div8_o),
        .err_o       (above_err),
        .err_valid_o (above_valid)
    );

    always_comb
    begin
        err_now.err_left  = left_valid ? left_err : err_q.err_left;
        err_now.err_above = above_valid ? above_err : err_q.err_above;
    end

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            err_q <= '0;
        end
        else
        begin
            err_q <= err_now;
        end
    end

    assign err_o = err_q;

    error_combiner u_comb (
        .clk258_x    (clk258_x),
        .reset_i     (reset_i),
        .own_i       (err_now),
        .own_valid_i (left_valid),
        .right_i     (right_i),
        .below_i     (below_i),
        .weights_i   (weights_i),
        .sum_o       (sum),
        .sum_valid_o (sum_valid)
    );

    loop_filter #(
        .KP_FRAC (KP_FRAC),
        .KI_FRAC (KI_FRAC)
    ) u_filter (
        .clk258_x  (clk258_x),
        .reset_i   (reset_i),
        .enable_i  (enable_i),
        .gains_i   (gains_i),
        .e_i       (sum),
        .e_valid_i (sum_valid),
        .ctrl_o    (ctrl)
    );

    // floored at zero so the dco never runs backwards
    assign word_sum = (DCO_WIDTH + 1)'(BIAS) + ctrl;
    assign dco_word = word_sum[DCO_WIDTH] ? '0 : word_sum[DCO_WIDTH-1:0];

    phase_accum #(
        .WIDTH (DCO_WIDTH)
    ) u_dco (
        .clk258_x (clk258_x),
        .reset_i  (reset_i),
        .word_i   (dco_word),
        .clk_o    (gen_o)
    );

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            gen_d <= 1'b0;
            div_q <= '0;
        end
        else
        begin
            gen_d <= gen_o;
            if (gen_o && !gen_d)
            begin
                div_q <= div_q + 3'd1;  // count dco rising edges
            end
        end
    end

    assign div8_o = div_q[2];

endmodule

/* rtl/error_combiner.sv */
`timescale 1ns/100ps

module error_combiner (
    input  logic                                    clk258_x,
    input  logic                                    reset_i,
    input  ring_net_pkg::node_err_t                 own_i,
    input  logic                                    own_valid_i,
    input  ring_net_pkg::node_err_t                 right_i,
    input  ring_net_pkg::node_err_t                 below_i,
    input  ring_net_pkg::weight_set_t               weights_i,
    output logic signed [ring_net_pkg::SUM_WIDTH-1:0] sum_o,
    output logic                                    sum_valid_o
);
    import ring_net_pkg::*;

    logic signed [SUM_WIDTH+1:0] prod_left, prod_above, prod_right, prod_below;
    logic signed [SUM_WIDTH+1:0] total;

    always_comb
    begin
        prod_left  = $signed({1'b0, weights_i.w_left}) * own_i.err_left;
        prod_above = $signed({1'b0, weights_i.w_above}) * own_i.err_above;
        prod_right = $signed({1'b0, weights_i.w_right}) * right_i.err_left;
        prod_below = $signed({1'b0, weights_i.w_below}) * below_i.err_above;
        total      = prod_left + prod_above - prod_right - prod_below;  // neighbours pull back
    end

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            sum_valid_o <= 1'b0;
        end
        else
        begin
            sum_valid_o <= own_valid_i;
        end
    end

    always_ff @(posedge clk258_x)
    begin
        if (own_valid_i)
        begin
            sum_o <= total[SUM_WIDTH+1:2];  // divide by 4, sign kept
        end
    end

endmodule

/* rtl/loop_filter.sv */
`timescale 1ns/100ps

module loop_filter #(
    parameter int KP_FRAC = 3,
    parameter int KI_FRAC = 6
) (
    input  logic                                      clk258_x,
    input  logic                                      reset_i,
    input  logic                                      enable_i,
    input  ring_net_pkg::gain_cfg_t                   gains_i,
    input  logic signed [ring_net_pkg::SUM_WIDTH-1:0] e_i,
    input  logic                                      e_valid_i,
    output logic signed [ring_net_pkg::DCO_WIDTH-1:0] ctrl_o
);
    import ring_net_pkg::*;

    localparam int IW = 18;
    localparam logic signed [IW-1:0] CTRL_MAX  = IW'(2 ** (DCO_WIDTH - 2) - 1);
    localparam logic signed [IW-1:0] INTEG_MAX = CTRL_MAX <<< KI_FRAC;

    logic signed [IW-1:0] p_term;
    logic signed [IW-1:0] integ_q;     // KI_FRAC fraction bits
    logic signed [IW-1:0] integ_next;
    logic signed [IW-1:0] ctrl_sum;

    function automatic logic signed [IW-1:0] clamp(input logic signed [IW-1:0] v,
                                                   input logic signed [IW-1:0] lim);
        if (v > lim)
            return lim;
        else if (v < -lim)
            return -lim;
        else
            return v;
    endfunction

    always_comb
    begin
        p_term     = ($signed({1'b0, gains_i.kp}) * e_i) >>> KP_FRAC;
        integ_next = clamp(integ_q + $signed({1'b0, gains_i.ki}) * e_i, INTEG_MAX);
        ctrl_sum   = clamp(p_term + (integ_next >>> KI_FRAC), CTRL_MAX);
    end

    always_ff @(posedge clk258_x)
    begin
        if (reset_i || !enable_i)
        begin
            integ_q <= '0;  // dco free-runs at bias
            ctrl_o  <= '0;
        end
        else if (e_valid_i)
        begin
            integ_q <= integ_next;
            ctrl_o  <= ctrl_sum[DCO_WIDTH-1:0];
        end
    end

endmodule

/* rtl/mesh_config.sv */
`timescale 1ns/100ps

module mesh_config (
    input  logic                                   clk258_x,
    input  logic                                   reset_i,
    input  ring_net_pkg::switch_word_u             cfg_word_i,
    output logic [ring_net_pkg::ACCUM_WIDTH-1:0]   ref_word_o,
    output ring_net_pkg::gain_cfg_t                gains_o,
    output logic                                   enable_o,
    output ring_net_pkg::weight_set_t [0:3]        weights_o
);
    import ring_net_pkg::*;

    // node order 11, 12, 21, 22; fields left/above/right/below
    localparam weight_set_t [0:3] UNI_TABLE = '{
        '{4'd4, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd4, 4'd0, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0}
    };
    localparam weight_set_t [0:3] BI_TABLE = '{
        '{4'd2, 4'd0, 4'd1, 4'd1},
        '{4'd2, 4'd0, 4'd0, 4'd2},
        '{4'd0, 4'd2, 4'd2, 4'd0},
        '{4'd2, 4'd2, 4'd0, 4'd0}
    };

    logic uni_dir_q;

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            ref_word_o <= '0;
            gains_o    <= '0;
            enable_o   <= 1'b0;
            uni_dir_q  <= 1'b0;
        end
        else
        begin
            enable_o  <= cfg_word_i.ref_view.enable;
            uni_dir_q <= cfg_word_i.ref_view.uni_dir;
            if (cfg_word_i.ref_view.load_ref)
            begin
                ref_word_o <= cfg_word_i.ref_view.ref_word;  // gains held
            end
            else
            begin
                gains_o.kp <= cfg_word_i.gain_view.kp;
                gains_o.ki <= cfg_word_i.gain_view.ki;
            end
        end
    end

    assign weights_o = uni_dir_q ? UNI_TABLE : BI_TABLE;

endmodule

/* rtl/phase_accum.sv */
`timescale 1ns/100ps

module phase_accum #(
    parameter int WIDTH = 8
) (
    input  logic             clk258_x,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] word_i,
    output logic             clk_o
);

    logic [WIDTH-1:0] accum_q;

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            accum_q <= '0;
        end
        else
        begin
            accum_q <= accum_q + word_i;  // wraps modulo 2^WIDTH
        end
    end

    assign clk_o = accum_q[WIDTH-1];  // msb is the square wave

    // half a turn per cycle or more would alias the output
    word_below_half_a : assert property (@(posedge clk258_x) disable iff (reset_i)
        !word_i[WIDTH-1]);

endmodule

/* rtl/phase_detector.sv */
`timescale 1ns/100ps

module phase_detector (
    input  logic                    clk258_x,
    input  logic                    reset_i,
    input  logic                    ref_i,
    input  logic                    fb_i,
    output ring_net_pkg::pdet_err_t err_o,
    output logic                    err_valid_o
);
    import ring_net_pkg::*;

    localparam pdet_err_t SAT_POS = 5'sd15;
    localparam pdet_err_t SAT_NEG = -5'sd15;

    logic      ref_d, fb_d;
    logic      ref_rise, fb_rise;
    logic      busy_q;     // first edge seen
    logic      ref_led_q;  // count direction
    pdet_err_t cnt_q;

    assign ref_rise = ref_i & ~ref_d;
    assign fb_rise  = fb_i & ~fb_d;

    always_ff @(posedge clk258_x)
    begin
        if (reset_i)
        begin
            ref_d       <= 1'b0;
            fb_d        <= 1'b0;
            busy_q      <= 1'b0;
            ref_led_q   <= 1'b0;
            cnt_q       <= '0;
            err_o       <= '0;
            err_valid_o <= 1'b0;
        end
        else
        begin
            ref_d       <= ref_i;
            fb_d        <= fb_i;
            err_valid_o <= 1'b0;
            if (!busy_q)
            begin
                if (ref_rise && fb_rise)
                begin
                    err_o       <= '0;  // aligned edges
                    err_valid_o <= 1'b1;
                end
                else if (ref_rise || fb_rise)
                begin
                    busy_q    <= 1'b1;
                    ref_led_q <= ref_rise;
                    cnt_q     <= ref_rise ? 5'sd1 : -5'sd1;
                end
            end
            else if (ref_led_q ? fb_rise : ref_rise)
            begin
                busy_q      <= 1'b0;  // lagging edge closes the window
                err_o       <= cnt_q;
                err_valid_o <= 1'b1;
            end
            else if (ref_led_q && cnt_q != SAT_POS)
            begin
                cnt_q <= cnt_q + 5'sd1;
            end
            else if (!ref_led_q && cnt_q != SAT_NEG)
            begin
                cnt_q <= cnt_q - 5'sd1;
            end
        end
    end

    single_strobe_a : assert property (@(posedge clk258_x) disable iff (reset_i)
        err_valid_o |=> !err_valid_o);

endmodule

/* rtl/ring_net_pkg.sv */
package ring_net_pkg;

    localparam int PDET_WIDTH  = 5;               // phase error bits
    localparam int ACCUM_WIDTH = 12;              // reference nco
    localparam int DCO_WIDTH   = 8;               // node dco accumulator
    localparam int SUM_WIDTH   = 2 * PDET_WIDTH;  // combined error

    typedef logic signed [PDET_WIDTH-1:0] pdet_err_t;

    typedef struct packed {
        pdet_err_t err_left;   // vs left reference
        pdet_err_t err_above;  // vs upper reference
    } node_err_t;

    typedef struct packed {
        logic [3:0] w_left;
        logic [3:0] w_above;
        logic [3:0] w_right;
        logic [3:0] w_below;
    } weight_set_t;

    typedef struct packed {
        logic [3:0] kp;
        logic [3:0] ki;
    } gain_cfg_t;

    typedef struct packed {
        logic                   enable;
        logic                   uni_dir;
        logic                   spare;
        logic                   load_ref;
        logic [ACCUM_WIDTH-1:0] ref_word;
    } ref_view_t;

    typedef struct packed {
        logic       enable;
        logic       uni_dir;
        logic       spare;
        logic       load_ref;
        logic [3:0] kp;
        logic [3:0] pad;
        logic [3:0] ki;
    } gain_view_t;

    // same 16 switches, meaning picked by load_ref
    typedef union packed {
        ref_view_t  ref_view;
        gain_view_t gain_view;
    } switch_word_u;

endpackage

/* verification/adpll_mesh_tb.sv */
`timescale 1ns/100ps

module adpll_mesh_tb;
    import ring_net_pkg::*;

    localparam int BIAS          = 30;
    localparam int REF_WORD      = 64;
    localparam int RESET_CYCLES  = 8;
    localparam int DECODE_WORDS  = 16;
    localparam int NCO_CYCLES    = 4096;
    localparam int SETTLE_CYCLES = 8000;
    localparam int WINDOW_CYCLES = 4096;
    localparam int PAUSE_CYCLES  = 16;
    localparam int EDGE_TOL      = 3;
    localparam int TEST_CYCLES   = RESET_CYCLES + 2 * DECODE_WORDS + 3 + NCO_CYCLES
                                 + 2 * (SETTLE_CYCLES + WINDOW_CYCLES + PAUSE_CYCLES + 2);
    localparam int TIMEOUT       = TEST_CYCLES * 3 / 2;

    logic         clk258_x;
    logic         reset_i;
    switch_word_u cfg_word;
    logic         ref_clk;
    logic [3:0]   gen;
    node_err_t    err11;
    gain_cfg_t    gains;

    int         seed;
    int         all_cyc;
    int         run_cyc;     // edges seen out of reset
    int         load_cyc;    // edge where ref_word was registered
    logic       free_run;
    logic       nco_on;
    gain_cfg_t  exp_gains;
    int         ref_edges;
    int         gen_edges [4];
    logic       ref_prev;
    logic [3:0] gen_prev;

    adpll_mesh_top #(
        .BIAS    (BIAS),
        .KP_FRAC (3),
        .KI_FRAC (6)
    ) dut0 (
        .clk258_x   (clk258_x),
        .reset_i    (reset_i),
        .cfg_word_i (cfg_word),
        .ref_clk_o  (ref_clk),
        .gen_o      (gen),
        .err11_o    (err11),
        .gains_o    (gains)
    );

    initial
    begin
        clk258_x = 1'b0;
        forever #2 clk258_x = ~clk258_x;
    end

    // msb of an accumulator that added word n times
    function automatic logic accum_msb(input longint word, input int width, input longint n);
        longint phase;
        phase = (word * n) % (64'sd1 <<< width);
        return phase[width-1];
    endfunction

    function automatic switch_word_u make_gain_word(input logic en, input logic uni,
                                                     input logic [3:0] kp, input logic [3:0] ki);
        switch_word_u w;
        w = '0;
        w.gain_view.enable  = en;
        w.gain_view.uni_dir = uni;
        w.gain_view.kp      = kp;
        w.gain_view.ki      = ki;
        return w;
    endfunction

    function automatic switch_word_u make_ref_word(input logic en, input logic uni,
                                                    input logic [ACCUM_WIDTH-1:0] word);
        switch_word_u w;
        w = '0;
        w.ref_view.enable   = en;
        w.ref_view.uni_dir  = uni;
        w.ref_view.load_ref = 1'b1;
        w.ref_view.ref_word = word;
        return w;
    endfunction

    task automatic check_gains(input string name, input gain_cfg_t exp, input gain_cfg_t act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected kp %0d ki %0d, actual kp %0d ki %0d",
                     name, exp.kp, exp.ki, act.kp, act.ki);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_phase_err(input string name, input pdet_err_t exp,
                                   input pdet_err_t act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act, input int tol);
        if (act < exp - tol || act > exp + tol)
        begin
            $display("FAILED %s: expected %0d +/- %0d, actual %0d", name, exp, tol, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk258_x)
    begin
        all_cyc <= all_cyc + 1;
        if (!reset_i)
            run_cyc <= run_cyc + 1;
        if (all_cyc >= TIMEOUT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk258_x)
    begin
        if (all_cyc > 0)
        begin
            if (reset_i || run_cyc <= 1)
            begin
                check_bit("reset ref_clk_o", 1'b0, ref_clk);
                for (int g = 0; g < 4; g++)
                    check_bit($sformatf("reset gen_o[%0d]", g), 1'b0, gen[g]);
                check_gains("reset gains_o", '0, gains);
            end
            if (!reset_i && free_run)
            begin
                for (int g = 0; g < 4; g++)
                    check_bit($sformatf("free run gen_o[%0d]", g),
                              accum_msb(BIAS, DCO_WIDTH, run_cyc), gen[g]);
            end
            if (nco_on && run_cyc >= load_cyc)
                check_bit("reference nco", accum_msb(REF_WORD, ACCUM_WIDTH, run_cyc - load_cyc),
                          ref_clk);
            check_gains("config decode gains_o", exp_gains, gains);
            if (gen_edges[0] > 4)
                check_phase_err("node 11 err_above", '0, err11.err_above);  // own div8 vs itself
            if (ref_clk && !ref_prev)
                ref_edges++;
            for (int g = 0; g < 4; g++)
                if (gen[g] && !gen_prev[g])
                    gen_edges[g]++;
            ref_prev = ref_clk;
            gen_prev = gen;
        end
    end

    task automatic run_lock(input string name, input logic uni);
        int ref_start;
        int node_start [4];
        @(posedge clk258_x);
        cfg_word <= make_gain_word(1'b1, uni, 4'd1, 4'd2);
        free_run <= 1'b0;  // loop may move the dco from here on
        @(posedge clk258_x);
        exp_gains <= {4'd1, 4'd2};
        repeat (SETTLE_CYCLES) @(posedge clk258_x);
        ref_start = ref_edges;
        for (int g = 0; g < 4; g++)
            node_start[g] = gen_edges[g];
        repeat (WINDOW_CYCLES) @(posedge clk258_x);
        for (int g = 0; g < 4; g++)
            check_count($sformatf("%s node %0d edges", name, g), 8 * (ref_edges - ref_start),
                        gen_edges[g] - node_start[g], EDGE_TOL);
    endtask

    initial
    begin
        logic [15:0] rnd;
        gain_cfg_t   pending;
        seed      = 32'hd49f9584;
        all_cyc   = 0;
        run_cyc   = 0;
        load_cyc  = 0;
        free_run  = 1'b1;
        nco_on    = 1'b0;
        exp_gains = '0;
        ref_edges = 0;
        gen_edges = '{0, 0, 0, 0};
        ref_prev  = 1'b0;
        gen_prev  = '0;
        reset_i   = 1'b1;
        cfg_word  = '0;
        repeat (RESET_CYCLES) @(posedge clk258_x);
        reset_i <= 1'b0;

        for (int i = 0; i < DECODE_WORDS; i++)
        begin
            @(posedge clk258_x);
            rnd = 16'($random(seed));
            cfg_word <= rnd & 16'h6fff;  // enable and load_ref low
            pending = {rnd[11:8], rnd[3:0]};
            @(posedge clk258_x);
            exp_gains <= pending;
        end

        @(posedge clk258_x);
        cfg_word <= make_ref_word(1'b0, 1'b0, '0);  // gains must hold, nco stays idle
        repeat (2) @(posedge clk258_x);

        @(posedge clk258_x);
        cfg_word <= make_ref_word(1'b0, 1'b0, ACCUM_WIDTH'(REF_WORD));
        load_cyc <= run_cyc + 2;  // config registers on the next edge
        nco_on   <= 1'b1;
        repeat (NCO_CYCLES) @(posedge clk258_x);

        run_lock("one-directional lock", 1'b1);

        @(posedge clk258_x);
        cfg_word <= make_gain_word(1'b0, 1'b0, 4'd1, 4'd2);
        repeat (PAUSE_CYCLES) @(posedge clk258_x);
        run_lock("bidirectional lock", 1'b0);

        $display("Verification passed");
        $finish;
    end

endmodule
